//--- rtl/spi_flash_pkg.sv
package spi_flash_pkg;

	// Field widths on the SPI side
	localparam int SPI_OP_W = 8;
	localparam int SPI_ADDR_W = 24;
	localparam int SPI_DATA_W = 8;

	// Full outgoing frame, command then address then data byte
	localparam int TX_W = SPI_OP_W + SPI_ADDR_W + SPI_DATA_W;

	// Phase bit counter, sized for the 24-bit address phase
	localparam int BIT_CNT_W = 5;

	// clk cycles per sclk half period
	localparam int SCLK_HALF = 2;
	localparam int DIV_W = $clog2(SCLK_HALF) + 1;

	// Flash command bytes
	typedef enum logic [SPI_OP_W-1:0] {
		OP_PROG = 8'h02,
		OP_READ = 8'h03,
		OP_RDSR = 8'h05,
		OP_WREN = 8'h06
	} spi_op_e;

	// Shift engine phases
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CMD,
		ST_ADDR,
		ST_WDATA,
		ST_RDATA,
		ST_FINISH
	} shift_state_e;

endpackage

//--- rtl/spi_regs_pkg.sv
package spi_regs_pkg;

	// AXI4-Lite bus widths
	localparam int AXI_ADDR_W = 5;
	localparam int AXI_DATA_W = 32;

	// Register offsets
	// Writing CTRL with a legal opcode launches a transaction
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL = 5'h00;
	localparam logic [AXI_ADDR_W-1:0] REG_ADDR = 5'h04;
	localparam logic [AXI_ADDR_W-1:0] REG_TXDATA = 5'h08;
	// Read-only
	localparam logic [AXI_ADDR_W-1:0] REG_RXDATA = 5'h0C;
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 5'h10;

	// Response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Status word layout
	localparam int STATUS_W = 2;
	localparam int STAT_BUSY = 0;
	localparam int STAT_DONE = 1;

endpackage

//--- rtl/spi_cmd_decode.sv
module spi_cmd_decode (
	input logic clk,
	input logic rst,
	// AXI4-Lite slave
	input logic [spi_regs_pkg::AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [spi_regs_pkg::AXI_DATA_W-1:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [spi_regs_pkg::AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [spi_regs_pkg::AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	// From engine and capture
	input logic busy,
	input logic [spi_flash_pkg::SPI_DATA_W-1:0] rx_data,
	input logic [spi_regs_pkg::STATUS_W-1:0] status,
	// Transaction request to the engine
	output logic start,
	output spi_flash_pkg::spi_op_e op_code,
	output logic has_addr,
	output logic has_wdata,
	output logic has_rdata,
	output logic [spi_flash_pkg::SPI_ADDR_W-1:0] addr,
	output logic [spi_flash_pkg::SPI_DATA_W-1:0] tx_data
);
	import spi_flash_pkg::*;
	import spi_regs_pkg::*;

	logic wr_acc;
	logic rd_acc;
	logic busy_any;
	logic op_legal;
	logic op_addr;
	logic op_wdata;
	logic op_rdata;
	logic wr_err;
	logic wr_go;
	logic [AXI_DATA_W-1:0] rd_word;
	logic rd_err;

	// AW and W taken together, only with no response outstanding
	assign wr_acc = awvalid & wvalid & ~bvalid;
	assign awready = wr_acc;
	assign wready = wr_acc;
	assign arready = ~rvalid;
	assign rd_acc = arvalid & ~rvalid;

	// A start still in flight counts as busy
	assign busy_any = busy | start;

	// Opcode to phase flags
	always_comb begin
		op_legal = 1'b1;
		op_addr = 1'b0;
		op_wdata = 1'b0;
		op_rdata = 1'b0;
		case (wdata[SPI_OP_W-1:0])
			OP_READ: begin
				op_addr = 1'b1;
				op_rdata = 1'b1;
			end
			OP_PROG: begin
				op_addr = 1'b1;
				op_wdata = 1'b1;
			end
			OP_RDSR: op_rdata = 1'b1;
			OP_WREN: op_legal = 1'b1;
			default: op_legal = 1'b0;
		endcase
	end

	// Write checks
	always_comb begin
		wr_go = 1'b0;
		case (awaddr)
			REG_CTRL: begin
				wr_err = busy_any | ~op_legal;
				wr_go = ~wr_err;
			end
			REG_ADDR, REG_TXDATA: wr_err = busy_any;
			// RO registers and holes
			default: wr_err = 1'b1;
		endcase
	end

	// Read mux
	always_comb begin
		rd_err = 1'b0;
		case (araddr)
			REG_CTRL: rd_word = AXI_DATA_W'(op_code);
			REG_ADDR: rd_word = AXI_DATA_W'(addr);
			REG_TXDATA: rd_word = AXI_DATA_W'(tx_data);
			REG_RXDATA: rd_word = AXI_DATA_W'(rx_data);
			REG_STATUS: rd_word = AXI_DATA_W'(status);
			default: begin
				rd_word = '0;
				rd_err = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
			rvalid <= 1'b0;
			rresp <= RESP_OKAY;
			start <= 1'b0;
			op_code <= OP_READ;
			has_addr <= 1'b0;
			has_wdata <= 1'b0;
			has_rdata <= 1'b0;
		end else begin
			start <= 1'b0;
			if (wr_acc) begin
				bvalid <= 1'b1;
				bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			// Flags stay put until the next accepted CTRL write
			if (wr_acc && wr_go) begin
				start <= 1'b1;
				op_code <= spi_op_e'(wdata[SPI_OP_W-1:0]);
				has_addr <= op_addr;
				has_wdata <= op_wdata;
				has_rdata <= op_rdata;
			end
			if (rd_acc) begin
				rvalid <= 1'b1;
				rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (wr_acc && !wr_err && awaddr == REG_ADDR)
			addr <= wdata[SPI_ADDR_W-1:0];
		if (wr_acc && !wr_err && awaddr == REG_TXDATA)
			tx_data <= wdata[SPI_DATA_W-1:0];
		if (rd_acc)
			rdata <= rd_word;
	end

endmodule

//--- rtl/spi_shift_engine.sv
module spi_shift_engine (
	input logic clk,
	input logic rst,
	input logic start,
	input spi_flash_pkg::spi_op_e op_code,
	input logic has_addr,
	input logic has_wdata,
	input logic has_rdata,
	input logic [spi_flash_pkg::SPI_ADDR_W-1:0] addr,
	input logic [spi_flash_pkg::SPI_DATA_W-1:0] wdata,
	output logic busy,
	output logic done,
	output logic [spi_flash_pkg::SPI_DATA_W-1:0] rx_byte,
	// SPI mode 0
	output logic sclk,
	output logic ss,
	output logic mosi,
	input logic miso
);
	import spi_flash_pkg::*;

	shift_state_e state;
	shift_state_e next_phase;
	logic [DIV_W-1:0] div_cnt;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [TX_W-1:0] tx_sr;
	logic half_end;
	logic rise;
	logic fall;

	// Divider only runs outside idle, so sclk rests low
	assign half_end = (div_cnt == DIV_W'(SCLK_HALF - 1));
	assign rise = half_end & ~sclk & busy;
	assign fall = half_end & sclk;

	assign busy = (state != ST_IDLE);
	// Frame MSB drives the line
	assign mosi = tx_sr[TX_W-1];

	// Phase after the current one ends
	always_comb begin
		next_phase = ST_FINISH;
		case (state)
			ST_CMD: begin
				if (has_addr)
					next_phase = ST_ADDR;
				else if (has_wdata)
					next_phase = ST_WDATA;
				else if (has_rdata)
					next_phase = ST_RDATA;
			end
			ST_ADDR: begin
				if (has_wdata)
					next_phase = ST_WDATA;
				else if (has_rdata)
					next_phase = ST_RDATA;
			end
			default: next_phase = ST_FINISH;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
			tx_sr <= '0;
			sclk <= 1'b0;
			ss <= 1'b1;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (state == ST_IDLE) begin
				if (start) begin
					state <= ST_CMD;
					ss <= 1'b0;
					div_cnt <= '0;
					bit_cnt <= BIT_CNT_W'(SPI_OP_W - 1);
					// Absent fields go out as zeros
					tx_sr <= {op_code, addr & {SPI_ADDR_W{has_addr}},
						wdata & {SPI_DATA_W{has_wdata}}};
				end
			end else begin
				div_cnt <= half_end ? '0 : div_cnt + 1'b1;
				if (half_end)
					sclk <= ~sclk;
				// Rising edge closes a bit
				if (rise) begin
					bit_cnt <= bit_cnt - 1'b1;
					if (bit_cnt == '0) begin
						state <= next_phase;
						if (next_phase == ST_ADDR)
							bit_cnt <= BIT_CNT_W'(SPI_ADDR_W - 1);
						else
							bit_cnt <= BIT_CNT_W'(SPI_DATA_W - 1);
					end
				end
				// Falling edge presents the next bit, or ends the frame
				if (fall) begin
					if (state == ST_FINISH) begin
						state <= ST_IDLE;
						ss <= 1'b1;
						done <= 1'b1;
						tx_sr <= '0;
					end else begin
						tx_sr <= {tx_sr[TX_W-2:0], 1'b0};
					end
				end
			end
		end
	end

	// miso taken on rising sclk during the read phase
	always_ff @(posedge clk) begin
		if (rise && state == ST_RDATA)
			rx_byte <= {rx_byte[SPI_DATA_W-2:0], miso};
	end

endmodule

//--- rtl/spi_rx_capture.sv
module spi_rx_capture (
	input logic clk,
	input logic rst,
	input logic start,
	input logic has_rdata,
	input logic busy,
	input logic done,
	input logic [spi_flash_pkg::SPI_DATA_W-1:0] rx_byte,
	output logic [spi_flash_pkg::SPI_DATA_W-1:0] rx_data,
	output logic [spi_regs_pkg::STATUS_W-1:0] status
);
	import spi_regs_pkg::*;

	// Set when the running transaction carries a read phase
	logic rd_phase;
	// Sticky completion flag
	logic done_bit;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_phase <= 1'b0;
			done_bit <= 1'b0;
			rx_data <= '0;
		end else begin
			if (start) begin
				rd_phase <= has_rdata;
				done_bit <= 1'b0;
			end else if (done) begin
				done_bit <= 1'b1;
				// Commands without a read phase keep the old byte
				if (rd_phase)
					rx_data <= rx_byte;
			end
		end
	end

	// Busy comes straight from the engine
	always_comb begin
		status = '0;
		status[STAT_BUSY] = busy;
		status[STAT_DONE] = done_bit;
	end

endmodule

//--- rtl/spi_flash_ctrl.sv
module spi_flash_ctrl (
	input logic clk,
	input logic rst,
	// AXI4-Lite slave
	input logic [spi_regs_pkg::AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [spi_regs_pkg::AXI_DATA_W-1:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [spi_regs_pkg::AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [spi_regs_pkg::AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	// Flash pins
	output logic sclk,
	output logic ss,
	output logic mosi,
	input logic miso
);
	import spi_flash_pkg::*;
	import spi_regs_pkg::*;

	// Decode to engine
	logic start;
	spi_op_e op_code;
	logic has_addr;
	logic has_wdata;
	logic has_rdata;
	logic [SPI_ADDR_W-1:0] spi_addr;
	logic [SPI_DATA_W-1:0] spi_wdata;
	// Engine and capture results
	logic busy;
	logic done;
	logic [SPI_DATA_W-1:0] rx_byte;
	logic [SPI_DATA_W-1:0] rx_data;
	logic [STATUS_W-1:0] status;

	spi_cmd_decode spi_cmd_decode_i (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.busy(busy), .rx_data(rx_data), .status(status),
		.start(start), .op_code(op_code), .has_addr(has_addr),
		.has_wdata(has_wdata), .has_rdata(has_rdata),
		.addr(spi_addr), .tx_data(spi_wdata)
	);

	spi_shift_engine spi_shift_engine_i (
		.clk(clk), .rst(rst), .start(start), .op_code(op_code),
		.has_addr(has_addr), .has_wdata(has_wdata), .has_rdata(has_rdata),
		.addr(spi_addr), .wdata(spi_wdata),
		.busy(busy), .done(done), .rx_byte(rx_byte),
		.sclk(sclk), .ss(ss), .mosi(mosi), .miso(miso)
	);

	spi_rx_capture spi_rx_capture_i (
		.clk(clk), .rst(rst), .start(start), .has_rdata(has_rdata),
		.busy(busy), .done(done), .rx_byte(rx_byte),
		.rx_data(rx_data), .status(status)
	);

endmodule

//--- dv/spi_flash_model.sv
module spi_flash_model (
	input logic sclk,
	input logic ss,
	input logic mosi,
	output logic miso
);
	import spi_flash_pkg::*;

	localparam logic [SPI_DATA_W-1:0] STATUS_BYTE = 8'h5A;
	localparam logic [SPI_DATA_W-1:0] READ_MASK = 8'hA5;

	// Frame progress, counted in rising sclk edges
	int bit_cnt = 0;
	logic [TX_W-1:0] in_sr = '0;
	logic [SPI_OP_W-1:0] cmd = '0;
	// Response byte and its load request for the next falling edge
	logic [SPI_DATA_W-1:0] resp_byte = '0;
	logic load = 1'b0;
	logic [SPI_DATA_W-1:0] out_sr = '0;
	logic miso_r = 1'b0;
	// Last programmed location
	logic prog_valid = 1'b0;
	logic [SPI_ADDR_W-1:0] prog_addr = '0;
	logic [SPI_DATA_W-1:0] prog_byte = '0;

	assign miso = miso_r;

	// sclk rests low at the ss fall, high at a rising edge
	always @(posedge sclk or negedge ss) begin
		if (!sclk) begin
			bit_cnt = 0;
			load = 1'b0;
		end else begin
			in_sr = {in_sr[TX_W-2:0], mosi};
			bit_cnt = bit_cnt + 1;
			load = 1'b0;
			if (bit_cnt == SPI_OP_W)
				cmd = in_sr[SPI_OP_W-1:0];
			// Status byte follows the command straight away
			if (bit_cnt == SPI_OP_W && cmd == OP_RDSR) begin
				resp_byte = STATUS_BYTE;
				load = 1'b1;
			end
			// Read data follows the last address bit
			if (bit_cnt == SPI_OP_W + SPI_ADDR_W && cmd == OP_READ) begin
				load = 1'b1;
				if (prog_valid && in_sr[SPI_ADDR_W-1:0] == prog_addr)
					resp_byte = prog_byte;
				else
					resp_byte = in_sr[SPI_DATA_W-1:0] ^ READ_MASK;
			end
			if (bit_cnt == TX_W && cmd == OP_PROG) begin
				prog_valid = 1'b1;
				prog_addr = in_sr[SPI_ADDR_W+SPI_DATA_W-1:SPI_DATA_W];
				prog_byte = in_sr[SPI_DATA_W-1:0];
			end
		end
	end

	// Mode 0, so miso moves on falling sclk, MSB first
	always @(negedge sclk) begin
		if (load)
			out_sr = resp_byte;
		miso_r = out_sr[SPI_DATA_W-1];
		out_sr = {out_sr[SPI_DATA_W-2:0], 1'b0};
	end

endmodule

//--- dv/spi_flash_ctrl_chk.sv
module spi_flash_ctrl_chk (
	input logic clk,
	input logic rst,
	input logic sclk,
	input logic ss,
	input logic bvalid,
	input logic bready,
	input logic [1:0] bresp,
	input logic rvalid,
	input logic rready,
	input logic [spi_regs_pkg::AXI_DATA_W-1:0] rdata,
	input logic [1:0] rresp,
	input logic start,
	input logic busy
);
	// Failure tallies, one per property
	int ss_fail = 0;
	int b_fail = 0;
	int r_fail = 0;
	int start_fail = 0;
	int fail_cnt;

	assign fail_cnt = ss_fail + b_fail + r_fail + start_fail;

	// Deselected flash sees a quiet clock
	ss_sclk_low: assert property (@(posedge clk) disable iff (rst) ss |-> !sclk)
		else begin
			$error("sclk high while ss is deasserted");
			ss_fail = ss_fail + 1;
		end

	// Write response held with its code until bready
	b_held: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin
			$error("write response dropped or changed before bready");
			b_fail = b_fail + 1;
		end

	// Read data held until rready
	r_held: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else begin
			$error("read response dropped or changed before rready");
			r_fail = r_fail + 1;
		end

	// One frame at a time
	start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
		else begin
			$error("start issued while the engine is busy");
			start_fail = start_fail + 1;
		end

endmodule

//--- dv/spi_flash_ctrl_tb.sv
module spi_flash_ctrl_tb;
	import spi_flash_pkg::*;
	import spi_regs_pkg::*;

	localparam int N_READS = 8;
	// Random reads plus wren, prog, readback, rdsr, wren and the busy-time read
	localparam int N_TXN = N_READS + 6;
	localparam int TIMEOUT = N_TXN * (40 * 4 + 40) + 200;

	logic clk;
	logic rst;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [AXI_DATA_W-1:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [AXI_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic sclk;
	logic ss;
	logic mosi;
	logic miso;

	logic [31:0] lfsr = 32'he5fe_bde1;
	int checks = 0;
	int errors = 0;
	int cycles = 0;
	// Expected flash contents under the flash rules
	logic prog_valid = 1'b0;
	logic [SPI_ADDR_W-1:0] prog_addr = '0;
	logic [SPI_DATA_W-1:0] prog_byte = '0;
	logic [SPI_DATA_W-1:0] rx_expect = '0;

	spi_flash_ctrl spi_flash_ctrl_i (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.sclk(sclk), .ss(ss), .mosi(mosi), .miso(miso)
	);

	spi_flash_model flash_i (.sclk(sclk), .ss(ss), .mosi(mosi), .miso(miso));

	bind spi_flash_ctrl spi_flash_ctrl_chk spi_flash_ctrl_chk_i (
		.clk(clk), .rst(rst), .sclk(sclk), .ss(ss),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.start(start), .busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[31]};
		end
	endtask

	// Low address byte scrambled, or the last programmed byte
	function automatic logic [SPI_DATA_W-1:0] expected_byte(input logic [SPI_ADDR_W-1:0] a);
		if (prog_valid && a == prog_addr)
			return prog_byte;
		return a[SPI_DATA_W-1:0] ^ 8'hA5;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s expected 0x%08h got 0x%08h", name, exp, act);
		end
	endtask

	// Called right after a rising edge
	// bready held low for 0 to 3 cycles
	task automatic write_check(input logic [4:0] a, input logic [31:0] d, input logic [1:0] exp);
		logic [31:0] stall;
		take_bits(2, stall);
		awaddr <= a;
		wdata <= d;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		@(posedge clk);
		while (!awready)
			@(posedge clk);
		// W channel taken in the same cycle as AW
		check_value("wready", 32'h1, 32'(wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		repeat (stall) @(posedge clk);
		bready <= 1'b1;
		@(posedge clk);
		while (!bvalid)
			@(posedge clk);
		check_value("bresp", 32'(exp), 32'(bresp));
		bready <= 1'b0;
	endtask

	task automatic read_reg(input logic [4:0] a, output logic [31:0] d, output logic [1:0] resp);
		logic [31:0] stall;
		take_bits(2, stall);
		araddr <= a;
		arvalid <= 1'b1;
		@(posedge clk);
		while (!arready)
			@(posedge clk);
		arvalid <= 1'b0;
		repeat (stall) @(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		while (!rvalid)
			@(posedge clk);
		d = rdata;
		resp = rresp;
		rready <= 1'b0;
	endtask

	task automatic read_check(input logic [4:0] a, input string name,
		input logic [31:0] exp, input logic [1:0] exp_resp);
		logic [31:0] d;
		logic [1:0] resp;
		read_reg(a, d, resp);
		check_value(name, exp, d);
		check_value("rresp", 32'(exp_resp), 32'(resp));
	endtask

	// Poll STATUS until the sticky done bit shows
	task automatic wait_done;
		logic [31:0] d;
		logic [1:0] resp;
		d = '0;
		while (d[STAT_DONE] !== 1'b1)
			read_reg(REG_STATUS, d, resp);
	endtask

	task automatic run_op(input spi_op_e op);
		write_check(REG_CTRL, 32'(op), RESP_OKAY);
		wait_done;
	endtask

	task automatic read_flash(input logic [SPI_ADDR_W-1:0] a);
		write_check(REG_ADDR, 32'(a), RESP_OKAY);
		run_op(OP_READ);
		rx_expect = expected_byte(a);
		read_check(REG_RXDATA, "rxdata", 32'(rx_expect), RESP_OKAY);
		// done set, busy clear
		read_check(REG_STATUS, "status", 32'h2, RESP_OKAY);
	endtask

	task automatic program_flash(input logic [SPI_ADDR_W-1:0] a, input logic [SPI_DATA_W-1:0] b);
		write_check(REG_ADDR, 32'(a), RESP_OKAY);
		write_check(REG_TXDATA, 32'(b), RESP_OKAY);
		run_op(OP_PROG);
		prog_valid = 1'b1;
		prog_addr = a;
		prog_byte = b;
	endtask

	task automatic close_run(input bit timed_out);
		int asrt;
		asrt = spi_flash_ctrl_i.spi_flash_ctrl_chk_i.fail_cnt;
		$display("Checks %0d, value errors %0d, assertion failures %0d, cycles %0d",
			checks, errors, asrt, cycles);
		if (!timed_out && errors == 0 && asrt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		// Random-address reads
		repeat (N_READS) begin
			take_bits(SPI_ADDR_W, a);
			read_flash(a[SPI_ADDR_W-1:0]);
		end
		// Write enable, one-byte program, readback
		take_bits(SPI_ADDR_W, a);
		take_bits(SPI_DATA_W, b);
		run_op(OP_WREN);
		program_flash(a[SPI_ADDR_W-1:0], b[SPI_DATA_W-1:0]);
		read_flash(a[SPI_ADDR_W-1:0]);
		// Flash status byte, then a frame with no read phase
		run_op(OP_RDSR);
		rx_expect = 8'h5A;
		read_check(REG_RXDATA, "rxdata", 32'(rx_expect), RESP_OKAY);
		run_op(OP_WREN);
		read_check(REG_RXDATA, "rxdata", 32'(rx_expect), RESP_OKAY);
		// Unknown opcode starts nothing
		write_check(REG_CTRL, 32'h0000_00AB, RESP_SLVERR);
		read_check(REG_STATUS, "status", 32'h2, RESP_OKAY);
		// CTRL write lands mid-frame
		take_bits(SPI_ADDR_W, a);
		write_check(REG_ADDR, 32'(a[SPI_ADDR_W-1:0]), RESP_OKAY);
		write_check(REG_CTRL, 32'(OP_READ), RESP_OKAY);
		write_check(REG_CTRL, 32'(OP_WREN), RESP_SLVERR);
		read_check(REG_STATUS, "status", 32'h1, RESP_OKAY);
		wait_done;
		rx_expect = expected_byte(a[SPI_ADDR_W-1:0]);
		read_check(REG_RXDATA, "rxdata", 32'(rx_expect), RESP_OKAY);
		// Read-only registers ignore writes
		write_check(REG_RXDATA, 32'hFFFF_FFFF, RESP_SLVERR);
		read_check(REG_RXDATA, "rxdata", 32'(rx_expect), RESP_OKAY);
		write_check(REG_STATUS, 32'hFFFF_FFFF, RESP_SLVERR);
		read_check(REG_STATUS, "status", 32'h2, RESP_OKAY);
		// Holes in the map
		read_check(5'h14, "rdata", 32'h0, RESP_SLVERR);
		read_check(5'h1C, "rdata", 32'h0, RESP_SLVERR);
		close_run(1'b0);
	end

	// Watchdog
	initial begin
		while (cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout, run still going after %0d cycles", cycles);
		close_run(1'b1);
	end

endmodule

//--- flist.f
rtl/spi_flash_pkg.sv
rtl/spi_regs_pkg.sv
rtl/spi_cmd_decode.sv
rtl/spi_shift_engine.sv
rtl/spi_rx_capture.sv
rtl/spi_flash_ctrl.sv
dv/spi_flash_model.sv
dv/spi_flash_ctrl_chk.sv
dv/spi_flash_ctrl_tb.sv

//--- Makefile
VERILATOR := verilator
TOP := spi_flash_ctrl_tb
FLIST := flist.f
OBJ_DIR := obj_dir
LINT_FLAGS := --lint-only --timing --assert -sv
SIM_FLAGS := --binary --timing --assert -sv -j 0
RUN_FLAGS := +verilator+error+limit+1000
PASS_MSG := Regression passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
